/* design/autotest_consts.svh */
/*
  Widths, record layout offsets, signature and SD block constants
  for the cipher self-test sequencer.
*/
`ifndef AUTOTEST_CONSTS_SVH
`define AUTOTEST_CONSTS_SVH

`define AT_BYTE_W      8
`define AT_BLOCK_W     64
`define AT_KEY_W       80
`define AT_OFS_W       10
`define AT_ADDR_W      32
`define AT_CYCLES_W    64
`define AT_ERR_W       32

`define AT_SD_BYTES    512
`define AT_SIGNATURE   32'hAABBCCDD
`define AT_START_BLOCK 32'h0010_0000

// byte offsets inside a record and its report
`define AT_OFS_ITER    4
`define AT_OFS_BLOCK   5
`define AT_OFS_KEY     13
`define AT_OFS_DIR     23
`define AT_OFS_EXP     24
`define AT_OFS_OUT     32
`define AT_OFS_TIME    40
`define AT_OFS_END     48

`endif

/* design/autotest_pkg.sv */
/*
  Data types of the self-test sequencer, the test vector struct
  and the sequencer state encoding.
*/
`default_nettype none
`include "autotest_consts.svh"

package autotest_pkg;

  typedef logic [`AT_BYTE_W-1:0]   byte_t;
  typedef logic [`AT_BLOCK_W-1:0]  block_t;
  typedef logic [`AT_KEY_W-1:0]    key_t;
  typedef logic [`AT_OFS_W-1:0]    offset_t;
  typedef logic [`AT_ADDR_W-1:0]   sd_addr_t;
  typedef logic [`AT_CYCLES_W-1:0] cycles_t;
  typedef logic [`AT_ERR_W-1:0]    err_count_t;

  typedef struct packed {
    logic [31:0] signature;
    byte_t       iteration;
    block_t      block;
    key_t        key;
    logic        dir;
    block_t      expected;
  } test_vector_t;

  typedef enum logic [4:0] {
    S_INIT, S_SPI_RST, S_SPI_WAIT, S_CLEAR,
    S_RD_BLOCK, S_RD_BLOCK_WAIT, S_RD_BYTE, S_RD_BYTE_WAIT,
    S_CHECK, S_RUN, S_COMPARE,
    S_WR_BLOCK, S_WR_BLOCK_WAIT, S_LOAD, S_WR_BYTE, S_WR_BYTE_WAIT,
    S_NEXT, S_HALT
  } at_state_e;

endpackage

`default_nettype wire

/* design/record_if.sv */
/*
  record_if: byte offset and strobes from the sequencer to the
  record capture and report datapaths
  result_if: run control of the result unit
*/
`timescale 1ns/1ps
`default_nettype none

interface record_if;
  import autotest_pkg::*;

  offset_t offset;
  logic    clear;
  logic    capture;
  logic    load;
  logic    sig_ok;

  modport ctrl (output offset, clear, capture, load, input sig_ok);
  modport vector (input offset, clear, capture, output sig_ok);
  modport report (input offset, load);
endinterface

interface result_if;
  logic clear;
  logic run;
  logic compare;
  logic test_end;

  modport ctrl (output clear, run, compare, input test_end);
  modport result (input clear, run, compare, output test_end);
endinterface

`default_nettype wire

/* design/vector_regs.sv */
/*
  Test vector registers: stores each captured record byte into the
  signature, iteration, block, key, direction or expected field,
  and flags a valid signature.
*/
`timescale 1ns/1ps
`default_nettype none
`include "autotest_consts.svh"

module vector_regs (
  input  wire                         clk,
  input  wire autotest_pkg::byte_t    spi_data_o_i,
  record_if.vector                    rec,
  output autotest_pkg::test_vector_t  vec_o
);
  import autotest_pkg::*;

  logic [1:0] sig_sel;
  offset_t    blk_rel;
  offset_t    key_rel;
  offset_t    exp_rel;

  // signature arrives msb first
  assign sig_sel = 2'd3 - rec.offset[1:0];
  assign blk_rel = rec.offset - offset_t'(`AT_OFS_BLOCK);
  assign key_rel = rec.offset - offset_t'(`AT_OFS_KEY);
  assign exp_rel = rec.offset - offset_t'(`AT_OFS_EXP);

  always_ff @(posedge clk) begin
    if (rec.clear) begin
      vec_o <= '0;
    end else if (rec.capture) begin
      if (rec.offset < offset_t'(`AT_OFS_ITER)) begin
        vec_o.signature[{sig_sel, 3'b000} +: 8] <= spi_data_o_i;
      end else if (rec.offset == offset_t'(`AT_OFS_ITER)) begin
        vec_o.iteration <= spi_data_o_i;
      end else if (rec.offset < offset_t'(`AT_OFS_KEY)) begin
        vec_o.block[{blk_rel[2:0], 3'b000} +: 8] <= spi_data_o_i;
      end else if (rec.offset < offset_t'(`AT_OFS_DIR)) begin
        vec_o.key[{key_rel[3:0], 3'b000} +: 8] <= spi_data_o_i;
      end else if (rec.offset == offset_t'(`AT_OFS_DIR)) begin
        // only bit 0 selects decrypt
        vec_o.dir <= spi_data_o_i[0];
      end else if (rec.offset < offset_t'(`AT_OFS_OUT)) begin
        vec_o.expected[{exp_rel[2:0], 3'b000} +: 8] <= spi_data_o_i;
      end
    end
  end

  assign rec.sig_ok = (vec_o.signature == `AT_SIGNATURE);

  // sequencer never clears while a byte is being stored
  a_capture_vs_clear: assert property (
    @(posedge clk) !(rec.capture === 1'b1 && rec.clear === 1'b1)
  ) else $error("capture and clear high together");

endmodule

`default_nettype wire

/* design/result_unit.sv */
/*
  Result unit: end flag select, execution timer, UUT output
  capture, compare against expected and error counter.
*/
`timescale 1ns/1ps
`default_nettype none

module result_unit (
  input  wire                          clk,
  input  wire                          rst,
  input  wire autotest_pkg::test_vector_t vec_i,
  input  wire autotest_pkg::block_t    block_o_uut_i,
  input  wire                          end_enc_uut_i,
  input  wire                          end_dec_uut_i,
  result_if.result                     res,
  output autotest_pkg::block_t         out_block_o,
  output autotest_pkg::cycles_t        exec_cycles_o,
  output autotest_pkg::err_count_t     error_count_o
);

  logic captured;

  // dir 1 means decrypt
  assign res.test_end = vec_i.dir ? end_dec_uut_i : end_enc_uut_i;

  always_ff @(posedge clk) begin
    if (rst || res.clear) begin
      exec_cycles_o <= '0;
    end else if (res.run && !res.test_end) begin
      exec_cycles_o <= exec_cycles_o + 1'b1;
    end
  end

  // keep the first output seen with the end flag
  always_ff @(posedge clk) begin
    if (rst || res.clear) begin
      captured    <= 1'b0;
      out_block_o <= '0;
    end else if (res.run && res.test_end && !captured) begin
      captured    <= 1'b1;
      out_block_o <= block_o_uut_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      error_count_o <= '0;
    end else if (res.compare && (out_block_o != vec_i.expected)) begin
      error_count_o <= error_count_o + 1'b1;
    end
  end

  // compare must follow the end of the run
  a_compare_after_run: assert property (
    @(posedge clk) disable iff (rst) !(res.compare && res.run)
  ) else $error("compare while the UUT is running");

endmodule

`default_nettype wire

/* design/report_formatter.sv */
/*
  Report formatter: picks the report byte for the current offset
  and registers it onto the SD write data.
*/
`timescale 1ns/1ps
`default_nettype none
`include "autotest_consts.svh"

module report_formatter (
  input  wire                             clk,
  input  wire                             rst,
  record_if.report                        rec,
  input  wire autotest_pkg::test_vector_t vec_i,
  input  wire autotest_pkg::block_t       out_block_i,
  input  wire autotest_pkg::cycles_t      exec_cycles_i,
  output autotest_pkg::byte_t             spi_data_i_o
);
  import autotest_pkg::*;

  logic [1:0] sig_sel;
  offset_t    rel;
  byte_t      rpt_byte;

  assign sig_sel = 2'd3 - rec.offset[1:0];

  always_comb begin
    rel      = '0;
    rpt_byte = 8'hFF;
    if (rec.offset < offset_t'(`AT_OFS_ITER)) begin
      rpt_byte = vec_i.signature[{sig_sel, 3'b000} +: 8];
    end else if (rec.offset == offset_t'(`AT_OFS_ITER)) begin
      rpt_byte = vec_i.iteration;
    end else if (rec.offset < offset_t'(`AT_OFS_KEY)) begin
      rel      = rec.offset - offset_t'(`AT_OFS_BLOCK);
      rpt_byte = vec_i.block[{rel[2:0], 3'b000} +: 8];
    end else if (rec.offset < offset_t'(`AT_OFS_DIR)) begin
      rel      = rec.offset - offset_t'(`AT_OFS_KEY);
      rpt_byte = vec_i.key[{rel[3:0], 3'b000} +: 8];
    end else if (rec.offset == offset_t'(`AT_OFS_DIR)) begin
      rpt_byte = {7'b0, vec_i.dir};
    end else if (rec.offset < offset_t'(`AT_OFS_OUT)) begin
      rel      = rec.offset - offset_t'(`AT_OFS_EXP);
      rpt_byte = vec_i.expected[{rel[2:0], 3'b000} +: 8];
    end else if (rec.offset < offset_t'(`AT_OFS_TIME)) begin
      rel      = rec.offset - offset_t'(`AT_OFS_OUT);
      rpt_byte = out_block_i[{rel[2:0], 3'b000} +: 8];
    end else if (rec.offset < offset_t'(`AT_OFS_END)) begin
      rel      = rec.offset - offset_t'(`AT_OFS_TIME);
      rpt_byte = exec_cycles_i[{rel[2:0], 3'b000} +: 8];
    end
  end

  // held until the next load so the host sees a stable byte
  always_ff @(posedge clk) begin
    if (rst) begin
      spi_data_i_o <= 8'hFF;
    end else if (rec.load) begin
      spi_data_i_o <= rpt_byte;
    end
  end

endmodule

`default_nettype wire

/* design/autotest_ctrl.sv */
/*
  Sequencer FSM: SD reset, record read, signature check, UUT run,
  compare and report write-back, with the byte offset and block
  address counters.
*/
`timescale 1ns/1ps
`default_nettype none
`include "autotest_consts.svh"

module autotest_ctrl (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     spi_busy_i,
  output logic                    spi_rst_o,
  output logic                    spi_r_block_o,
  output logic                    spi_r_byte_o,
  output logic                    spi_w_block_o,
  output logic                    spi_w_byte_o,
  output autotest_pkg::sd_addr_t  spi_block_addr_o,
  output logic                    rst_uut_o,
  output logic                    halted_o,
  record_if.ctrl                  rec,
  result_if.ctrl                  res
);
  import autotest_pkg::*;

  at_state_e state;
  at_state_e state_nxt;
  offset_t   offset;
  sd_addr_t  block_addr;
  logic      offset_clr;
  logic      offset_inc;
  logic      addr_inc;
  logic      last_byte;

  assign last_byte        = (offset == offset_t'(`AT_SD_BYTES - 1));
  assign rec.offset       = offset;
  assign spi_block_addr_o = block_addr;
  assign halted_o         = (state == S_HALT);

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= S_INIT;
      offset     <= '0;
      block_addr <= `AT_START_BLOCK;
    end else begin
      state <= state_nxt;
      if (offset_clr) begin
        offset <= '0;
      end else if (offset_inc) begin
        offset <= offset + 1'b1;
      end
      if (addr_inc) begin
        block_addr <= block_addr + 1'b1;
      end
    end
  end

  always_comb begin
    state_nxt     = state;
    spi_rst_o     = 1'b0;
    spi_r_block_o = 1'b0;
    spi_r_byte_o  = 1'b0;
    spi_w_block_o = 1'b0;
    spi_w_byte_o  = 1'b0;
    rst_uut_o     = 1'b1;
    rec.clear     = 1'b0;
    rec.capture   = 1'b0;
    rec.load      = 1'b0;
    res.clear     = 1'b0;
    res.run       = 1'b0;
    res.compare   = 1'b0;
    offset_clr    = 1'b0;
    offset_inc    = 1'b0;
    addr_inc      = 1'b0;
    case (state)
      S_INIT: state_nxt = S_SPI_RST;
      S_SPI_RST: begin
        spi_rst_o = 1'b1;
        if (spi_busy_i) state_nxt = S_SPI_WAIT;
      end
      S_SPI_WAIT: if (!spi_busy_i) state_nxt = S_CLEAR;
      S_CLEAR: begin
        rec.clear  = 1'b1;
        res.clear  = 1'b1;
        offset_clr = 1'b1;
        if (!spi_busy_i) state_nxt = S_RD_BLOCK;
      end
      // r_block stays high for the whole block read
      S_RD_BLOCK: begin
        spi_r_block_o = 1'b1;
        if (spi_busy_i) state_nxt = S_RD_BLOCK_WAIT;
      end
      S_RD_BLOCK_WAIT: begin
        spi_r_block_o = 1'b1;
        if (!spi_busy_i) state_nxt = S_RD_BYTE;
      end
      S_RD_BYTE: begin
        spi_r_block_o = 1'b1;
        spi_r_byte_o  = 1'b1;
        if (spi_busy_i) state_nxt = S_RD_BYTE_WAIT;
      end
      S_RD_BYTE_WAIT: begin
        spi_r_block_o = 1'b1;
        if (!spi_busy_i) begin
          rec.capture = 1'b1;
          offset_inc  = 1'b1;
          state_nxt   = last_byte ? S_CHECK : S_RD_BYTE;
        end
      end
      S_CHECK: state_nxt = rec.sig_ok ? S_RUN : S_HALT;
      S_RUN: begin
        rst_uut_o = 1'b0;
        res.run   = 1'b1;
        if (res.test_end) state_nxt = S_COMPARE;
      end
      S_COMPARE: begin
        res.compare = 1'b1;
        offset_clr  = 1'b1;
        state_nxt   = S_WR_BLOCK;
      end
      S_WR_BLOCK: begin
        spi_w_block_o = 1'b1;
        if (spi_busy_i) state_nxt = S_WR_BLOCK_WAIT;
      end
      S_WR_BLOCK_WAIT: begin
        spi_w_block_o = 1'b1;
        if (!spi_busy_i) state_nxt = S_LOAD;
      end
      S_LOAD: begin
        spi_w_block_o = 1'b1;
        rec.load      = 1'b1;
        state_nxt     = S_WR_BYTE;
      end
      S_WR_BYTE: begin
        spi_w_block_o = 1'b1;
        spi_w_byte_o  = 1'b1;
        if (spi_busy_i) state_nxt = S_WR_BYTE_WAIT;
      end
      S_WR_BYTE_WAIT: begin
        spi_w_block_o = 1'b1;
        if (!spi_busy_i) begin
          offset_inc = 1'b1;
          state_nxt  = last_byte ? S_NEXT : S_LOAD;
        end
      end
      S_NEXT: begin
        addr_inc  = 1'b1;
        state_nxt = S_CLEAR;
      end
      S_HALT: state_nxt = S_HALT;
      default: state_nxt = S_INIT;
    endcase
  end

  a_no_rw_byte: assert property (
    @(posedge clk) disable iff (rst) !(spi_r_byte_o && spi_w_byte_o)
  ) else $error("read and write byte requests together");

  a_offset_range: assert property (
    @(posedge clk) disable iff (rst)
    (rec.capture || rec.load) |-> (offset < offset_t'(`AT_SD_BYTES))
  ) else $error("byte offset past end of block");

endmodule

`default_nettype wire

/* design/autotest_top.sv */
/*
  Self-test sequencer top level: sequencer, vector registers,
  result unit and report formatter with their interfaces.
*/
`timescale 1ns/1ps
`default_nettype none

module autotest_top (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           spi_busy_i,
  input  wire autotest_pkg::byte_t      spi_data_o_i,
  output logic                          spi_rst_o,
  output logic                          spi_r_block_o,
  output logic                          spi_r_byte_o,
  output logic                          spi_w_block_o,
  output logic                          spi_w_byte_o,
  output autotest_pkg::sd_addr_t        spi_block_addr_o,
  output autotest_pkg::byte_t           spi_data_i_o,
  output logic                          rst_uut_o,
  output autotest_pkg::block_t          block_i_uut_o,
  output autotest_pkg::key_t            key_uut_o,
  output logic                          encdec_uut_o,
  input  wire autotest_pkg::block_t     block_o_uut_i,
  input  wire                           end_enc_uut_i,
  input  wire                           end_dec_uut_i,
  output autotest_pkg::err_count_t      error_count_o,
  output logic                          halted_o
);
  import autotest_pkg::*;

  test_vector_t vec;
  block_t       out_block;
  cycles_t      exec_cycles;

  record_if rec ();
  result_if res ();

  autotest_ctrl i_autotest_ctrl (
    .clk              (clk),
    .rst              (rst),
    .spi_busy_i       (spi_busy_i),
    .spi_rst_o        (spi_rst_o),
    .spi_r_block_o    (spi_r_block_o),
    .spi_r_byte_o     (spi_r_byte_o),
    .spi_w_block_o    (spi_w_block_o),
    .spi_w_byte_o     (spi_w_byte_o),
    .spi_block_addr_o (spi_block_addr_o),
    .rst_uut_o        (rst_uut_o),
    .halted_o         (halted_o),
    .rec              (rec.ctrl),
    .res              (res.ctrl)
  );

  vector_regs i_vector_regs (
    .clk          (clk),
    .spi_data_o_i (spi_data_o_i),
    .rec          (rec.vector),
    .vec_o        (vec)
  );

  result_unit i_result_unit (
    .clk           (clk),
    .rst           (rst),
    .vec_i         (vec),
    .block_o_uut_i (block_o_uut_i),
    .end_enc_uut_i (end_enc_uut_i),
    .end_dec_uut_i (end_dec_uut_i),
    .res           (res.result),
    .out_block_o   (out_block),
    .exec_cycles_o (exec_cycles),
    .error_count_o (error_count_o)
  );

  report_formatter i_report_formatter (
    .clk           (clk),
    .rst           (rst),
    .rec           (rec.report),
    .vec_i         (vec),
    .out_block_i   (out_block),
    .exec_cycles_i (exec_cycles),
    .spi_data_i_o  (spi_data_i_o)
  );

  // UUT parameters straight from the captured record
  assign block_i_uut_o = vec.block;
  assign key_uut_o     = vec.key;
  assign encdec_uut_o  = vec.dir;

endmodule

`default_nettype wire

/* tb/tb_sd_card.sv */
/*
  Behavioral SD host model: block array, busy pulse with random
  delays on every request, byte read and byte write-back.
*/
`timescale 1ns/1ps
`default_nettype none
`include "autotest_consts.svh"

module tb_sd_card (
  input  wire        clk,
  input  wire        rst,
  input  wire        spi_rst_i,
  input  wire        r_block_i,
  input  wire        r_byte_i,
  input  wire        w_block_i,
  input  wire        w_byte_i,
  input  wire [31:0] block_addr_i,
  input  wire [7:0]  data_i,
  output logic       busy_o,
  output logic [7:0] data_o
);
  localparam int NBLK = 8;

  logic [7:0]  mem [0:NBLK*512-1];
  int          wr_bytes [0:NBLK-1];
  int          wblk_req [0:NBLK-1];
  int          bad_addr;
  logic [31:0] seed;
  int          phase;
  int          cnt;
  int          kind;
  int          idx;
  int          ptr;
  logic        p_rst, p_rb, p_rbyte, p_wb, p_wbyte;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  initial begin
    busy_o   = 1'b0;
    data_o   = 8'hFF;
    seed     = 32'hd548_5d1b;
    phase    = 0;
    cnt      = 0;
    kind     = 0;
    idx      = 0;
    ptr      = 0;
    bad_addr = 0;
    {p_rst, p_rb, p_rbyte, p_wb, p_wbyte} = 5'b0;
    for (int b = 0; b < NBLK; b++) begin
      wr_bytes[b] = 0;
      wblk_req[b] = 0;
    end
  end

  // requests are rising edges, seen on the falling clock edge
  always @(negedge clk) begin
    if (rst) begin
      phase  = 0;
      busy_o = 1'b0;
    end else begin
      case (phase)
        0: begin
          kind = 0;
          if (spi_rst_i && !p_rst) kind = 1;
          else if (r_block_i && !p_rb) kind = 2;
          else if (r_byte_i && !p_rbyte) kind = 3;
          else if (w_block_i && !p_wb) kind = 4;
          else if (w_byte_i && !p_wbyte) kind = 5;
          if (kind != 0) begin
            seed  = lcg_next(seed);
            cnt   = 2 + int'(seed[17:16]);
            phase = 1;
          end
        end
        1: begin
          cnt = cnt - 1;
          if (cnt == 0) begin
            busy_o = 1'b1;
            if (kind == 2 || kind == 4) begin
              idx = int'(block_addr_i - `AT_START_BLOCK);
              ptr = 0;
              if (idx < 0 || idx >= NBLK) begin
                bad_addr = bad_addr + 1;
                idx      = 0;
              end else if (kind == 4) begin
                wblk_req[idx] = wblk_req[idx] + 1;
              end
            end else if (kind == 3 && ptr < 512) begin
              data_o = mem[idx*512 + ptr];
              ptr    = ptr + 1;
            end
            seed  = lcg_next(seed);
            cnt   = 1 + int'(seed[18:16]);
            phase = 2;
          end
        end
        default: begin
          cnt = cnt - 1;
          if (cnt == 0) begin
            busy_o = 1'b0;
            if (kind == 5 && ptr < 512) begin
              mem[idx*512 + ptr] = data_i;
              wr_bytes[idx]      = wr_bytes[idx] + 1;
              ptr                = ptr + 1;
            end
            phase = 0;
          end
        end
      endcase
    end
    {p_rst, p_rb, p_rbyte, p_wb, p_wbyte} =
      {spi_rst_i, r_block_i, r_byte_i, w_block_i, w_byte_i};
  end

endmodule

`default_nettype wire

/* tb/tb_autotest.sv */
/*
  Testbench of the self-test sequencer with clock, reset, toy cipher
  UUT, SD model, vector table and report checks.
*/
`timescale 1ns/1ps
`default_nettype none
`include "autotest_consts.svh"

module tb_autotest;
  import autotest_pkg::*;

  localparam int NROWS = 5;
  localparam block_t TBL_BLOCK [NROWS] = '{64'h0123_4567_89AB_CDEF,
    64'hFEDC_BA98_7654_3210, 64'h0F1E_2D3C_4B5A_6978, 64'hDEAD_BEEF_CAFE_F00D,
    64'h1111_2222_3333_4444};
  localparam key_t TBL_KEY [NROWS] = '{80'h0000_1111_2222_3333_4444,
    80'hA5A5_5A5A_A5A5_5A5A_A5A5, 80'h1234_5678_9ABC_DEF0_1357,
    80'hFFFF_0000_FFFF_0000_FFFF, 80'h0BAD_0BAD_0BAD_0BAD_0BAD};
  localparam logic TBL_DIR    [NROWS] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
  localparam logic TBL_EXP_OK [NROWS] = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b1};
  localparam logic TBL_SIG_OK [NROWS] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0};

  logic       clk, rst, spi_busy, rst_uut, encdec, end_enc, end_dec, halted;
  logic       spi_rst, r_block, r_byte, w_block, w_byte;
  byte_t      sd_rd_data, sd_wr_data;
  sd_addr_t   block_addr;
  block_t     uut_in, uut_out;
  key_t       uut_key;
  err_count_t error_count;
  logic [7:0] rec_mem [0:NROWS*512-1];
  int         uut_cnt, test_errs, tests_ok, tests_bad, exp_errors;
  logic [63:0] cycles;
  logic       hung;

  autotest_top i_autotest_top (
    .clk(clk), .rst(rst), .spi_busy_i(spi_busy), .spi_data_o_i(sd_rd_data),
    .spi_rst_o(spi_rst), .spi_r_block_o(r_block), .spi_r_byte_o(r_byte),
    .spi_w_block_o(w_block), .spi_w_byte_o(w_byte),
    .spi_block_addr_o(block_addr), .spi_data_i_o(sd_wr_data),
    .rst_uut_o(rst_uut), .block_i_uut_o(uut_in), .key_uut_o(uut_key),
    .encdec_uut_o(encdec), .block_o_uut_i(uut_out), .end_enc_uut_i(end_enc),
    .end_dec_uut_i(end_dec), .error_count_o(error_count), .halted_o(halted)
  );

  tb_sd_card i_sd (
    .clk(clk), .rst(rst), .spi_rst_i(spi_rst), .r_block_i(r_block),
    .r_byte_i(r_byte), .w_block_i(w_block), .w_byte_i(w_byte),
    .block_addr_i(block_addr), .data_i(sd_wr_data), .busy_o(spi_busy),
    .data_o(sd_rd_data)
  );

  function automatic block_t toy_cipher(input block_t b, input key_t k, input logic d);
    block_t x;
    x = b ^ k[63:0];
    return d ? {x[55:0], x[63:56]} : x;
  endfunction

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // toy UUT raises the matching end flag after 20 cycles and the other one early
  always @(negedge clk) begin
    if (rst_uut) uut_cnt = 0;
    else if (uut_cnt < 60) uut_cnt = uut_cnt + 1;
    end_enc = encdec ? (uut_cnt >= 5) : (uut_cnt > 20);
    end_dec = encdec ? (uut_cnt > 20) : (uut_cnt >= 5);
    uut_out = toy_cipher(uut_in, uut_key, encdec);
  end

  task automatic build_record(input int r);
    logic [31:0] sig;
    block_t      exp_blk;
    sig     = TBL_SIG_OK[r] ? `AT_SIGNATURE : 32'h5A5A_0F0F;
    exp_blk = toy_cipher(TBL_BLOCK[r], TBL_KEY[r], TBL_DIR[r]) ^ {63'b0, !TBL_EXP_OK[r]};
    for (int i = 0; i < 512; i++) begin
      rec_mem[r*512 + i] = 8'((i ^ (i >> 8) ^ (r * 37)) & 255);
    end
    for (int i = 0; i < 4; i++) rec_mem[r*512 + i] = sig[(3-i)*8 +: 8];
    rec_mem[r*512 + `AT_OFS_ITER] = 8'(r);
    for (int i = 0; i < 8; i++) rec_mem[r*512 + `AT_OFS_BLOCK + i] = TBL_BLOCK[r][i*8 +: 8];
    for (int i = 0; i < 10; i++) rec_mem[r*512 + `AT_OFS_KEY + i] = TBL_KEY[r][i*8 +: 8];
    rec_mem[r*512 + `AT_OFS_DIR] = {7'b0, TBL_DIR[r]};
    for (int i = 0; i < 8; i++) rec_mem[r*512 + `AT_OFS_EXP + i] = exp_blk[i*8 +: 8];
    for (int i = 0; i < 512; i++) i_sd.mem[r*512 + i] = rec_mem[r*512 + i];
  endtask

  task automatic expect_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_report(input int r);
    block_t res;
    int     t;
    t = 0;
    while (i_sd.wr_bytes[r] < 512 && t < 200000) begin
      @(negedge clk);
      t++;
    end
    if (i_sd.wr_bytes[r] < 512) begin
      $display("no report was written for test %0d before the timeout", r);
      hung = 1'b1;
      test_errs++;
    end else begin
      res = toy_cipher(TBL_BLOCK[r], TBL_KEY[r], TBL_DIR[r]);
      expect_eq("bad_addr", 64'(i_sd.bad_addr), 64'd0);
      expect_eq("halted_o", 64'(halted), 64'd0);
      for (int i = 0; i < 32; i++)
        expect_eq($sformatf("report[%0d]", i), 64'(i_sd.mem[r*512+i]), 64'(rec_mem[r*512+i]));
      for (int i = 0; i < 8; i++)
        expect_eq($sformatf("report[%0d]", 32+i), 64'(i_sd.mem[r*512+32+i]), 64'(res[i*8 +: 8]));
      for (int i = 0; i < 8; i++) cycles[i*8 +: 8] = i_sd.mem[r*512 + 40 + i];
      assert (cycles >= 64'd20 && cycles < 64'd40) else begin
        $display("ERR exec_cycles: got 0x%0h, expected 0x14 to 0x27", cycles);
        test_errs++;
      end
      for (int i = 48; i < 512; i++)
        expect_eq($sformatf("report[%0d]", i), 64'(i_sd.mem[r*512+i]), 64'hFF);
    end
  endtask

  task automatic check_halt(input int r);
    int t;
    t = 0;
    while (!halted && t < 200000) begin
      @(negedge clk);
      t++;
    end
    if (!halted) begin
      $display("the sequencer did not halt at test %0d before the timeout", r);
      hung = 1'b1;
      test_errs++;
    end else begin
      repeat (100) @(negedge clk);
      expect_eq("halted_o", 64'(halted), 64'd1);
      expect_eq("write requests", 64'(i_sd.wblk_req[r]), 64'd0);
      expect_eq("spi_block_addr_o", 64'(block_addr), 64'(`AT_START_BLOCK + r));
    end
  endtask

  task automatic end_test(input string name);
    if (test_errs == 0) tests_ok++;
    else tests_bad++;
    $display("%s: %s (%0d errors)", name, (test_errs == 0) ? "ok" : "FAILED", test_errs);
    test_errs = 0;
  endtask

  initial begin
    rst = 1'b1;
    uut_cnt = 0;
    end_enc = 1'b0;
    end_dec = 1'b0;
    uut_out = '0;
    test_errs = 0;
    tests_ok = 0;
    tests_bad = 0;
    exp_errors = 0;
    hung = 1'b0;
    for (int r = 0; r < NROWS; r++) build_record(r);
    repeat (2) @(negedge clk);
    rst = 1'b0;
    for (int r = 0; r < NROWS && !hung; r++) begin
      if (TBL_SIG_OK[r]) begin
        check_report(r);
        if (!TBL_EXP_OK[r]) exp_errors++;
      end else begin
        check_halt(r);
      end
      end_test($sformatf("test %0d", r));
    end
    expect_eq("error_count_o", 64'(error_count), 64'(exp_errors));
    end_test("error count");
    $display("summary: %0d ok, %0d failing", tests_ok, tests_bad);
    if (tests_bad == 0) $display("all tests passed");
    else $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* autotest.f */
+incdir+design
design/autotest_pkg.sv
design/record_if.sv
design/vector_regs.sv
design/result_unit.sv
design/report_formatter.sv
design/autotest_ctrl.sv
design/autotest_top.sv
tb/tb_sd_card.sv
tb/tb_autotest.sv

/* Makefile */
# Verilator build for the self-test sequencer testbench

OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module tb_autotest -f autotest.f --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/Vtb_autotest | tee $(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
